/* hw/rx_dcore_pkg.sv */
package rx_dcore_pkg;

    ////////////////////
    // sizes
    ////////////////////

    // interleaved lanes handled per clk_adc cycle
    localparam int N_LANES = 16;

    // ADC code width
    localparam int N_ADC = 8;

    // phase interpolator code width and output count
    localparam int N_PI = 9;
    localparam int N_OUT = 4;

    // analog max-select width per PI output
    localparam int MAX_SEL_W = 4;

    ////////////////////
    // PRBS
    ////////////////////

    // PRBS7, each bit is the XOR of the bits 6 and 7 back
    localparam int PRBS_ORDER = 7;
    localparam int PRBS_TAP_A = 6;
    localparam int PRBS_TAP_B = 7;

    // settling interval of 32 cycles after reset
    localparam int HOLD_CYCLES_W = 5;

    // error and total counter width
    localparam int CNT_W = 64;

    ////////////////////
    // types
    ////////////////////

    typedef logic signed [N_ADC-1:0] adc_code_t;

    // lane 0 is the earliest bit in time
    typedef logic [N_LANES-1:0] lane_bits_t;

    typedef logic [N_PI-1:0] pi_code_t;

    typedef struct packed {
        logic                             ext_scale_en;
        pi_code_t [N_OUT-1:0]             ext_scale;
        logic     [N_OUT-1:0][MAX_SEL_W-1:0] max_sel;
        pi_code_t [N_OUT-1:0]             offset;
    } pi_cfg_t;

    // src_sel picks the sliced ADC bits (0) or the BIST word (1)
    typedef struct packed {
        logic                  src_sel;
        logic                  gen_en;
        logic                  gen_load;
        logic [PRBS_ORDER-1:0] gen_seed;
        logic                  inj_err;
        logic                  check_en;
        logic                  count_clear;
    } prbs_cfg_t;

    typedef struct packed {
        logic [CNT_W/2-1:0] upper;
        logic [CNT_W/2-1:0] lower;
    } cnt_halves_t;

    // counter word, incremented whole and read back as two 32-bit halves
    typedef union packed {
        logic [CNT_W-1:0] count;
        cnt_halves_t      half;
    } prbs_count_u;

endpackage

/* hw/reset_hold.sv */
module reset_hold (
    input  logic clk_adc,
    input  logic cdr_rstb,
    output logic ctl_valid_o
);

    logic [rx_dcore_pkg::HOLD_CYCLES_W-1:0] hold_cnt_q;
    logic                                   hold_done;

    // terminal count reached
    assign hold_done = &hold_cnt_q;

    // saturating counter, valid follows the terminal count by one edge
    // so the level rises on the 32nd edge after release
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            hold_cnt_q  <= '0;
            ctl_valid_o <= 1'b0;
        end else begin
            if (!hold_done) begin
                hold_cnt_q <= hold_cnt_q + 1'b1;
            end
            ctl_valid_o <= hold_done;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // once the loops are released they stay released until the next reset
    a_valid_sticky : assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        ctl_valid_o |=> ctl_valid_o
    ) else $error("ctl_valid_o fell without a reset");

endmodule

/* hw/pi_ctl_mapper.sv */
module pi_ctl_mapper (
    input  logic                   clk_adc,
    input  logic                   cdr_rstb,
    input  rx_dcore_pkg::pi_code_t pi_code_i [rx_dcore_pkg::N_OUT],
    input  rx_dcore_pkg::pi_cfg_t  pi_cfg_i,
    output rx_dcore_pkg::pi_code_t pi_ctl_o [rx_dcore_pkg::N_OUT]
);

    rx_dcore_pkg::pi_code_t scale  [rx_dcore_pkg::N_OUT];
    rx_dcore_pkg::pi_code_t mapped [rx_dcore_pkg::N_OUT];

    ////////////////////
    // wrap and offset
    ////////////////////

    always_comb begin
        for (int j = 0; j < rx_dcore_pkg::N_OUT; j++) begin
            // (max_sel+1)*16-1 is max_sel with four ones appended
            if (pi_cfg_i.ext_scale_en) begin
                scale[j] = pi_cfg_i.ext_scale[j];
            end else begin
                scale[j] = rx_dcore_pkg::pi_code_t'({pi_cfg_i.max_sel[j], 4'hf});
            end

            // sum wraps at N_PI bits
            mapped[j] = (pi_code_i[j] % scale[j]) + pi_cfg_i.offset[j];
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            for (int j = 0; j < rx_dcore_pkg::N_OUT; j++) begin
                pi_ctl_o[j] <= '0;
            end
        end else begin
            for (int j = 0; j < rx_dcore_pkg::N_OUT; j++) begin
                pi_ctl_o[j] <= mapped[j];
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // external override or analog select must never give a zero modulus
    for (genvar j = 0; j < rx_dcore_pkg::N_OUT; j++) begin : g_scale_chk
        a_scale_nonzero : assert property (
            @(posedge clk_adc) disable iff (!cdr_rstb)
            scale[j] != '0
        ) else $error("PI output %0d selected a zero scale", j);
    end

endmodule

/* hw/code_slicer.sv */
module code_slicer (
    input  logic                     clk_adc,
    input  logic                     cdr_rstb,
    input  rx_dcore_pkg::adc_code_t  codes_i [rx_dcore_pkg::N_LANES],
    input  rx_dcore_pkg::adc_code_t  thresh_i,
    output rx_dcore_pkg::lane_bits_t bits_o
);

    rx_dcore_pkg::lane_bits_t decision;

    ////////////////////
    // hard decisions
    ////////////////////

    // both sides signed, lane k maps to bit k
    always_comb begin
        for (int k = 0; k < rx_dcore_pkg::N_LANES; k++) begin
            decision[k] = codes_i[k] > thresh_i;
        end
    end

    // one register stage from codes to bits
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            bits_o <= '0;
        end else begin
            bits_o <= decision;
        end
    end

endmodule

/* hw/prbs_bist_gen.sv */
module prbs_bist_gen (
    input  logic                     clk_adc,
    input  logic                     cdr_rstb,
    input  rx_dcore_pkg::prbs_cfg_t  cfg_i,
    output rx_dcore_pkg::lane_bits_t bits_o
);

    // state holds the last PRBS_ORDER bits, oldest in bit 0
    logic [rx_dcore_pkg::PRBS_ORDER-1:0] state_q;

    // state followed by the sixteen bits of this cycle
    logic [rx_dcore_pkg::PRBS_ORDER+rx_dcore_pkg::N_LANES-1:0] seq;

    rx_dcore_pkg::lane_bits_t next_bits;

    ////////////////////
    // unrolled recurrence
    ////////////////////

    always_comb begin
        seq = '0;
        seq[rx_dcore_pkg::PRBS_ORDER-1:0] = state_q;
        for (int k = 0; k < rx_dcore_pkg::N_LANES; k++) begin
            seq[rx_dcore_pkg::PRBS_ORDER+k] =
                seq[rx_dcore_pkg::PRBS_ORDER+k-rx_dcore_pkg::PRBS_TAP_A] ^
                seq[rx_dcore_pkg::PRBS_ORDER+k-rx_dcore_pkg::PRBS_TAP_B];
        end
    end

    assign next_bits = seq[rx_dcore_pkg::PRBS_ORDER +: rx_dcore_pkg::N_LANES];

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q <= '1;
            bits_o  <= '0;
        end else if (cfg_i.gen_load) begin
            state_q <= cfg_i.gen_seed;
        end else if (cfg_i.gen_en) begin
            state_q <= seq[rx_dcore_pkg::N_LANES +: rx_dcore_pkg::PRBS_ORDER];
            // flip lane 0 only, the state keeps the clean sequence
            bits_o  <= next_bits ^ rx_dcore_pkg::lane_bits_t'(cfg_i.inj_err);
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // a zero seed would lock the sequence at zero
    a_state_nonzero : assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        state_q != '0
    ) else $error("PRBS generator state is all zero");

endmodule

/* hw/prbs_checker.sv */
module prbs_checker (
    input  logic                      clk_adc,
    input  logic                      cdr_rstb,
    input  rx_dcore_pkg::prbs_cfg_t   cfg_i,
    input  rx_dcore_pkg::lane_bits_t  rx_bits_i,
    output rx_dcore_pkg::prbs_count_u err_count_o,
    output rx_dcore_pkg::prbs_count_u total_count_o
);

    // received history, oldest bit in bit 0
    logic [rx_dcore_pkg::PRBS_ORDER-1:0] hist_q;

    // history has been filled since reset or clear
    logic primed_q;

    logic [rx_dcore_pkg::PRBS_ORDER+rx_dcore_pkg::N_LANES-1:0] seq;
    rx_dcore_pkg::lane_bits_t                                  mismatch;
    logic [$clog2(rx_dcore_pkg::N_LANES+1)-1:0]                n_err;

    ////////////////////
    // self-sync compare
    ////////////////////

    // the received bits themselves predict each new bit
    assign seq = {rx_bits_i, hist_q};

    always_comb begin
        n_err = '0;
        for (int k = 0; k < rx_dcore_pkg::N_LANES; k++) begin
            mismatch[k] = seq[rx_dcore_pkg::PRBS_ORDER+k] ^
                          seq[rx_dcore_pkg::PRBS_ORDER+k-rx_dcore_pkg::PRBS_TAP_A] ^
                          seq[rx_dcore_pkg::PRBS_ORDER+k-rx_dcore_pkg::PRBS_TAP_B];
            n_err = n_err + mismatch[k];
        end
    end

    ////////////////////
    // counters
    ////////////////////

    // clear wins over counting
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            hist_q        <= '0;
            primed_q      <= 1'b0;
            err_count_o   <= '0;
            total_count_o <= '0;
        end else if (cfg_i.count_clear) begin
            primed_q      <= 1'b0;
            err_count_o   <= '0;
            total_count_o <= '0;
        end else if (cfg_i.check_en) begin
            hist_q   <= seq[rx_dcore_pkg::N_LANES +: rx_dcore_pkg::PRBS_ORDER];
            primed_q <= 1'b1;
            // first word only fills the history
            if (primed_q) begin
                err_count_o.count   <= err_count_o.count + n_err;
                total_count_o.count <= total_count_o.count + rx_dcore_pkg::N_LANES;
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    a_err_le_total : assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        err_count_o.count <= total_count_o.count
    ) else $error("PRBS error count exceeds total count");

endmodule

/* hw/rx_dcore_top.sv */
module rx_dcore_top (
    input  logic                      clk_adc,
    input  logic                      cdr_rstb,
    input  rx_dcore_pkg::adc_code_t   adc_codes_i [rx_dcore_pkg::N_LANES],
    input  rx_dcore_pkg::adc_code_t   thresh_i,
    input  rx_dcore_pkg::pi_code_t    pi_code_i [rx_dcore_pkg::N_OUT],
    input  rx_dcore_pkg::pi_cfg_t     pi_cfg_i,
    input  rx_dcore_pkg::prbs_cfg_t   prbs_cfg_i,
    output logic                      ctl_valid_o,
    output rx_dcore_pkg::pi_code_t    pi_ctl_o [rx_dcore_pkg::N_OUT],
    output rx_dcore_pkg::prbs_count_u err_count_o,
    output rx_dcore_pkg::prbs_count_u total_count_o
);

    rx_dcore_pkg::lane_bits_t adc_bits;
    rx_dcore_pkg::lane_bits_t bist_bits;
    rx_dcore_pkg::lane_bits_t rx_bits;

    ////////////////////
    // control paths
    ////////////////////

    reset_hold u_reset_hold (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .ctl_valid_o (ctl_valid_o)
    );

    pi_ctl_mapper u_pi_map (
        .clk_adc   (clk_adc),
        .cdr_rstb  (cdr_rstb),
        .pi_code_i (pi_code_i),
        .pi_cfg_i  (pi_cfg_i),
        .pi_ctl_o  (pi_ctl_o)
    );

    ////////////////////
    // BIST path
    ////////////////////

    code_slicer u_slicer (
        .clk_adc  (clk_adc),
        .cdr_rstb (cdr_rstb),
        .codes_i  (adc_codes_i),
        .thresh_i (thresh_i),
        .bits_o   (adc_bits)
    );

    prbs_bist_gen u_bist_gen (
        .clk_adc  (clk_adc),
        .cdr_rstb (cdr_rstb),
        .cfg_i    (prbs_cfg_i),
        .bits_o   (bist_bits)
    );

    // generator register feeds the checker with no extra stage
    assign rx_bits = prbs_cfg_i.src_sel ? bist_bits : adc_bits;

    prbs_checker u_checker (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .cfg_i         (prbs_cfg_i),
        .rx_bits_i     (rx_bits),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

endmodule

/* tests/tb_rx_dcore.sv */
module tb_rx_dcore;

    // cycles per test, the run limit is twice their sum
    localparam int T_RESET = 45;
    localparam int T_PI    = 202;
    localparam int T_BIST  = 104;
    localparam int T_INJ   = 52;
    localparam int T_ADC   = 153;
    localparam int T_CLEAR = 5;
    localparam int LIMIT   = 2 * (T_RESET + T_PI + T_BIST + T_INJ + T_ADC + T_CLEAR);

    logic                      clk_adc;
    logic                      cdr_rstb;
    rx_dcore_pkg::adc_code_t   adc_codes [rx_dcore_pkg::N_LANES];
    rx_dcore_pkg::adc_code_t   thresh;
    rx_dcore_pkg::pi_code_t    pi_code [rx_dcore_pkg::N_OUT];
    rx_dcore_pkg::pi_cfg_t     pi_cfg;
    rx_dcore_pkg::prbs_cfg_t   prbs_cfg;
    logic                      ctl_valid;
    rx_dcore_pkg::pi_code_t    pi_ctl [rx_dcore_pkg::N_OUT];
    rx_dcore_pkg::prbs_count_u err_count;
    rx_dcore_pkg::prbs_count_u total_count;

    logic [15:0] lfsr_q;
    int          cycle_cnt;
    int          test_err;
    int          total_err;
    int          tests_run;
    int          tests_failed;

    // model state, history index d is the bit d positions back
    logic [7:1]               g_hist;
    rx_dcore_pkg::lane_bits_t m_gen_out;
    rx_dcore_pkg::lane_bits_t m_adc_bits;
    logic [7:1]               c_hist;
    logic                     c_primed;
    logic [63:0]              c_err;
    logic [63:0]              c_total;

    rx_dcore_top uut (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .adc_codes_i   (adc_codes),
        .thresh_i      (thresh),
        .pi_code_i     (pi_code),
        .pi_cfg_i      (pi_cfg),
        .prbs_cfg_i    (prbs_cfg),
        .ctl_valid_o   (ctl_valid),
        .pi_ctl_o      (pi_ctl),
        .err_count_o   (err_count),
        .total_count_o (total_count)
    );

    initial begin
        clk_adc = 1'b0;
        forever #2 clk_adc = ~clk_adc;
    end

    always @(posedge clk_adc) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > LIMIT) begin
            $display("timeout: the run went past %0d cycles without finishing", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////
    // random source
    ////////////////////

    // taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic fill_codes();
        for (int k = 0; k < rx_dcore_pkg::N_LANES; k++) begin
            adc_codes[k] = rx_dcore_pkg::adc_code_t'(rand_bits(8));
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    function automatic rx_dcore_pkg::pi_code_t pi_expect(input int code, input logic en,
                                                         input int ext, input int msel,
                                                         input int off);
        int s;
        s = en ? ext : (msel + 1) * 16 - 1;
        return rx_dcore_pkg::pi_code_t'(((code % s) + off) % 512);
    endfunction

    // one clock edge of the data path, using the inputs driven now
    task automatic advance_model();
        rx_dcore_pkg::lane_bits_t rx;
        rx_dcore_pkg::lane_bits_t word;
        logic                     b;
        rx = prbs_cfg.src_sel ? m_gen_out : m_adc_bits;
        if (prbs_cfg.count_clear) begin
            c_err    = '0;
            c_total  = '0;
            c_primed = 1'b0;
        end else if (prbs_cfg.check_en) begin
            for (int k = 0; k < rx_dcore_pkg::N_LANES; k++) begin
                b = rx[k];
                if (c_primed && (b != (c_hist[6] ^ c_hist[7]))) begin
                    c_err = c_err + 1;
                end
                c_hist = {c_hist[6:1], b};
            end
            if (c_primed) begin
                c_total = c_total + 16;
            end
            c_primed = 1'b1;
        end
        if (prbs_cfg.gen_load) begin
            // seed bit 6 is the newest bit
            for (int d = 1; d <= 7; d++) begin
                g_hist[d] = prbs_cfg.gen_seed[7-d];
            end
        end else if (prbs_cfg.gen_en) begin
            for (int k = 0; k < rx_dcore_pkg::N_LANES; k++) begin
                b = g_hist[6] ^ g_hist[7];
                word[k] = b;
                g_hist = {g_hist[6:1], b};
            end
            word[0] = word[0] ^ prbs_cfg.inj_err;
            m_gen_out = word;
        end
        for (int k = 0; k < rx_dcore_pkg::N_LANES; k++) begin
            m_adc_bits[k] = $signed(adc_codes[k]) > $signed(thresh);
        end
    endtask

    ////////////////////
    // helpers
    ////////////////////

    task automatic step_cycle();
        advance_model();
        @(posedge clk_adc);
        #1;
    endtask

    task automatic note_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        test_err = test_err + 1;
    endtask

    task automatic compare_counts();
        if (err_count.count !== c_err) begin
            note_error($sformatf("err count %0d, model %0d", err_count.count, c_err));
        end
        if (total_count.count !== c_total) begin
            note_error($sformatf("total count %0d, model %0d", total_count.count, c_total));
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-12s %s, %0d errors", name, (test_err == 0) ? "ok" : "failed", test_err);
        tests_run = tests_run + 1;
        if (test_err != 0) begin
            tests_failed = tests_failed + 1;
        end
        total_err = total_err + test_err;
        test_err = 0;
    endtask

    ////////////////////
    // tests
    ////////////////////

    initial begin
        logic [63:0]            base_err;
        logic [63:0]            base_tot;
        rx_dcore_pkg::pi_code_t exp_pi [rx_dcore_pkg::N_OUT];
        cdr_rstb = 1'b0;
        pi_cfg = '0;
        prbs_cfg = '0;
        thresh = '0;
        for (int k = 0; k < rx_dcore_pkg::N_LANES; k++) begin
            adc_codes[k] = '0;
        end
        for (int j = 0; j < rx_dcore_pkg::N_OUT; j++) begin
            pi_code[j] = '0;
        end
        lfsr_q = 16'd40;
        cycle_cnt = 0;
        test_err = 0;
        total_err = 0;
        tests_run = 0;
        tests_failed = 0;
        g_hist = '1;
        m_gen_out = '0;
        m_adc_bits = '0;
        c_hist = '0;
        c_primed = 1'b0;
        c_err = '0;
        c_total = '0;

        // reset hold
        repeat (3) @(posedge clk_adc);
        #1;
        if (ctl_valid !== 1'b0) begin
            note_error("ctl_valid high during reset");
        end
        cdr_rstb = 1'b1;
        for (int n = 1; n <= 40; n++) begin
            step_cycle();
            if (ctl_valid !== (n >= 32)) begin
                note_error($sformatf("ctl_valid %b after edge %0d", ctl_valid, n));
            end
        end
        finish_test("reset_hold");

        // pi mapping
        for (int i = 0; i < 200; i++) begin
            pi_cfg.ext_scale_en = lfsr_bit();
            for (int j = 0; j < rx_dcore_pkg::N_OUT; j++) begin
                pi_code[j] = rand_bits(9);
                pi_cfg.max_sel[j] = rand_bits(4);
                pi_cfg.offset[j] = rand_bits(9);
                pi_cfg.ext_scale[j] = rand_bits(9);
                if (pi_cfg.ext_scale[j] == '0) begin
                    pi_cfg.ext_scale[j] = 9'd1;
                end
                exp_pi[j] = pi_expect(pi_code[j], pi_cfg.ext_scale_en, pi_cfg.ext_scale[j],
                                      pi_cfg.max_sel[j], pi_cfg.offset[j]);
            end
            step_cycle();
            for (int j = 0; j < rx_dcore_pkg::N_OUT; j++) begin
                if (pi_ctl[j] !== exp_pi[j]) begin
                    note_error($sformatf("pi_ctl[%0d] %0d, expected %0d", j, pi_ctl[j],
                                         exp_pi[j]));
                end
            end
        end
        finish_test("pi_map");

        // clean bist, seed load and clear first
        prbs_cfg.src_sel = 1'b1;
        prbs_cfg.gen_load = 1'b1;
        prbs_cfg.gen_seed = rand_bits(7);
        if (prbs_cfg.gen_seed == '0) begin
            prbs_cfg.gen_seed = 7'd1;
        end
        prbs_cfg.count_clear = 1'b1;
        step_cycle();
        prbs_cfg.gen_load = 1'b0;
        prbs_cfg.count_clear = 1'b0;
        prbs_cfg.gen_en = 1'b1;
        step_cycle();
        prbs_cfg.check_en = 1'b1;
        repeat (100) begin
            step_cycle();
            compare_counts();
        end
        if (err_count.count !== 64'd0) begin
            note_error($sformatf("clean BIST counted %0d errors", err_count.count));
        end
        if (total_count.count !== 64'd1584) begin
            note_error($sformatf("total %0d, expected 1584", total_count.count));
        end
        if (total_count.half.upper !== 32'd0 || total_count.half.lower !== 32'd1584) begin
            note_error("total halves do not read 0 and 1584");
        end
        finish_test("bist_clean");

        // spaced single-bit injections
        for (int p = 0; p < 5; p++) begin
            base_err = err_count.count;
            base_tot = total_count.count;
            prbs_cfg.inj_err = 1'b1;
            step_cycle();
            compare_counts();
            prbs_cfg.inj_err = 1'b0;
            repeat (9) begin
                step_cycle();
                compare_counts();
            end
            if (err_count.count - base_err !== 64'd3) begin
                note_error($sformatf("pulse %0d added %0d errors", p, err_count.count - base_err));
            end
            if (total_count.count - base_tot !== 64'd160) begin
                note_error($sformatf("pulse %0d total grew by %0d", p,
                                     total_count.count - base_tot));
            end
        end
        finish_test("bist_inject");

        // sliced adc path
        prbs_cfg.src_sel = 1'b0;
        prbs_cfg.count_clear = 1'b1;
        thresh = rx_dcore_pkg::adc_code_t'(rand_bits(8));
        fill_codes();
        step_cycle();
        prbs_cfg.count_clear = 1'b0;
        repeat (150) begin
            fill_codes();
            step_cycle();
            compare_counts();
        end
        if (total_count.count !== 64'd2384) begin
            note_error($sformatf("adc total %0d, expected 2384", total_count.count));
        end
        finish_test("adc_path");

        // clear then one priming word
        prbs_cfg.count_clear = 1'b1;
        step_cycle();
        if (err_count.count !== 64'd0 || total_count.count !== 64'd0) begin
            note_error("counts not zero after count_clear");
        end
        prbs_cfg.count_clear = 1'b0;
        step_cycle();
        if (total_count.count !== 64'd0) begin
            note_error("first word after clear added to the total");
        end
        step_cycle();
        if (total_count.count !== 64'd16) begin
            note_error($sformatf("total %0d after two words, expected 16", total_count.count));
        end
        compare_counts();
        finish_test("clear");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_err);
        if (total_err == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
hw/rx_dcore_pkg.sv
hw/reset_hold.sv
hw/pi_ctl_mapper.sv
hw/code_slicer.sv
hw/prbs_bist_gen.sv
hw/prbs_checker.sv
hw/rx_dcore_top.sv
tests/tb_rx_dcore.sv

/* Bender.yml */
package:
  name: rx_dcore

sources:
  - files:
      - hw/rx_dcore_pkg.sv
      - hw/reset_hold.sv
      - hw/pi_ctl_mapper.sv
      - hw/code_slicer.sv
      - hw/prbs_bist_gen.sv
      - hw/prbs_checker.sv
      - hw/rx_dcore_top.sv
  - target: test
    files:
      - tests/tb_rx_dcore.sv
